// ==== Makefile ====
# Verilator build and run of the north port arbiter testbench.

TOP = n_rr_processor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f n_rr_processor.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== grant_hold_timer.sv ====
`timescale 1ns/1ps

`include "n_rr_config.svh"

module grant_hold_timer (
        input  logic clk,
        input  logic rst_i,
        input  logic load_i,
        output logic done_o
);

        localparam int unsigned HOLD_W = `N_RR_HOLD_W;

        typedef logic [HOLD_W-1:0] hold_cnt_t;

        // Counting down to zero gives exactly one cycle per flit.
        localparam hold_cnt_t LOAD_VAL = hold_cnt_t'(`N_RR_PACKET_FLITS - 1);

        hold_cnt_t cnt_q;
        logic      run_q;

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        cnt_q <= '0;
                        run_q <= 1'b0;
                end else if (load_i) begin
                        cnt_q <= LOAD_VAL;
                        run_q <= 1'b1;
                end else if (run_q) begin
                        if (cnt_q == '0) begin
                                run_q <= 1'b0; // Packet is over.
                        end else begin
                                cnt_q <= cnt_q - 1'b1;
                        end
                end
        end

        assign done_o = run_q && (cnt_q == '0);

endmodule

// ==== n_route_decoder.sv ====
`timescale 1ns/1ps

module n_route_decoder (
        input  noc_port_pkg::port_addr_t s_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t w_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t e_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t l_nexthop_addr_i,
        output rr_arb_pkg::req_vec_t     req_o
);

        import noc_port_pkg::*;
        import rr_arb_pkg::*;

        // The other output arbiters differ only in this code.
        localparam port_code_t TARGET_PORT = PORT_N;

        always_comb begin
                req_o       = '0;
                req_o[IN_S] = (s_nexthop_addr_i == TARGET_PORT);
                req_o[IN_W] = (w_nexthop_addr_i == TARGET_PORT);
                req_o[IN_E] = (e_nexthop_addr_i == TARGET_PORT);
                req_o[IN_L] = (l_nexthop_addr_i == TARGET_PORT);
        end

endmodule

// ==== n_rr_config.svh ====
`ifndef N_RR_CONFIG_SVH
`define N_RR_CONFIG_SVH

// Number of router inputs that can compete for the north output.
`define N_RR_INPUTS 4

// Grant hold length in clock cycles, one cycle per flit (legal range 1 to 15).
`define N_RR_PACKET_FLITS 4

// Width of the flit down-counter, wide enough for the largest packet.
`define N_RR_HOLD_W 4

`endif

// ==== n_rr_processor.f ====
+incdir+.
noc_port_pkg.sv
rr_arb_pkg.sv
n_route_decoder.sv
rr_priority_ring.sv
rr_grant_select.sv
grant_hold_timer.sv
rr_arb_fsm.sv
n_rr_processor.sv
n_rr_processor_assertions.sv
n_rr_processor_tb.sv

// ==== n_rr_processor.sv ====
`timescale 1ns/1ps

module n_rr_processor (
        input  logic                     clk,
        input  logic                     rst_i,
        input  noc_port_pkg::port_addr_t s_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t w_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t e_nexthop_addr_i,
        input  noc_port_pkg::port_addr_t l_nexthop_addr_i,
        output logic                     grant_s_o,
        output logic                     grant_w_o,
        output logic                     grant_e_o,
        output logic                     grant_l_o,
        output noc_port_pkg::port_addr_t to_cs_o
);

        import rr_arb_pkg::*;

        req_vec_t req;
        rr_ptr_t  ptr;
        rr_ptr_t  win_idx;
        logic     win_valid;
        logic     timer_load;
        logic     timer_done;
        logic     rotate;
        rr_ptr_t  last_idx;

        n_route_decoder u_decoder (
                .s_nexthop_addr_i (s_nexthop_addr_i),
                .w_nexthop_addr_i (w_nexthop_addr_i),
                .e_nexthop_addr_i (e_nexthop_addr_i),
                .l_nexthop_addr_i (l_nexthop_addr_i),
                .req_o            (req)
        );

        rr_priority_ring u_ring (
                .clk        (clk),
                .rst_i      (rst_i),
                .rotate_i   (rotate),
                .last_idx_i (last_idx),
                .ptr_o      (ptr)
        );

        rr_grant_select u_select (
                .req_i       (req),
                .ptr_i       (ptr),
                .win_idx_o   (win_idx),
                .win_valid_o (win_valid)
        );

        grant_hold_timer u_timer (
                .clk    (clk),
                .rst_i  (rst_i),
                .load_i (timer_load),
                .done_o (timer_done)
        );

        rr_arb_fsm u_fsm (
                .clk          (clk),
                .rst_i        (rst_i),
                .win_idx_i    (win_idx),
                .win_valid_i  (win_valid),
                .timer_done_i (timer_done),
                .timer_load_o (timer_load),
                .rotate_o     (rotate),
                .last_idx_o   (last_idx),
                .grant_s_o    (grant_s_o),
                .grant_w_o    (grant_w_o),
                .grant_e_o    (grant_e_o),
                .grant_l_o    (grant_l_o),
                .to_cs_o      (to_cs_o)
        );

endmodule

// ==== n_rr_processor_assertions.sv ====
`timescale 1ns/1ps

`include "n_rr_config.svh"

module n_rr_processor_assertions (
        input logic                     clk,
        input logic                     rst_i,
        input logic                     grant_s_i,
        input logic                     grant_w_i,
        input logic                     grant_e_i,
        input logic                     grant_l_i,
        input noc_port_pkg::port_addr_t to_cs_i
);

        import noc_port_pkg::*;
        import rr_arb_pkg::*;

        typedef logic [`N_RR_HOLD_W:0] run_len_t;

        localparam run_len_t HOLD_MAX = run_len_t'(`N_RR_PACKET_FLITS);

        req_vec_t grants;
        run_len_t run_len;
        logic     fail_onehot = 1'b0;
        logic     fail_cs     = 1'b0;
        logic     fail_hold   = 1'b0;

        assign grants = {grant_l_i, grant_e_i, grant_w_i, grant_s_i};

        // Cycles the running grant was held before the current one.
        always_ff @(posedge clk) begin
                if (rst_i) begin
                        run_len <= '0;
                end else if (grants != '0) begin
                        run_len <= run_len + 1'b1;
                end else begin
                        run_len <= '0;
                end
        end

        one_grant_a: assert property (@(posedge clk) disable iff (rst_i) $onehot0(grants))
        else begin
                fail_onehot = 1'b1;
                $error("more than one grant high: %b", grants);
        end

        cs_idle_a: assert property (@(posedge clk) disable iff (rst_i)
                (to_cs_i == PORT_NONE) == (grants == '0))
        else begin
                fail_cs = 1'b1;
                $error("to_cs %0d does not fit grants %b", to_cs_i, grants);
        end

        hold_len_a: assert property (@(posedge clk) disable iff (rst_i)
                (grants != '0) |-> (run_len < HOLD_MAX))
        else begin
                fail_hold = 1'b1;
                $error("grant held longer than one packet");
        end

endmodule

bind n_rr_processor n_rr_processor_assertions u_assertions (
        .clk       (clk),
        .rst_i     (rst_i),
        .grant_s_i (grant_s_o),
        .grant_w_i (grant_w_o),
        .grant_e_i (grant_e_o),
        .grant_l_i (grant_l_o),
        .to_cs_i   (to_cs_o)
);

// ==== n_rr_processor_tb.sv ====
`timescale 1ns/1ps

`include "n_rr_config.svh"

module n_rr_processor_tb;

        import noc_port_pkg::*;
        import rr_arb_pkg::*;

        localparam int CLK_PERIOD    = 4;
        localparam int DRIVE_DELAY   = 1;
        localparam int N_IN          = `N_RR_INPUTS;
        localparam int FLITS         = `N_RR_PACKET_FLITS;
        localparam int RANDOM_CYCLES = 500;
        localparam int GRANT_TIMEOUT = 2 * (FLITS + 2) + 4;

        // Cycles of all six tests, the resets between them included.
        localparam int TEST_CYCLES = 6 * 3 + 6 + (FLITS + 4) + 5 * (FLITS + 2)
                                     + 2 * (FLITS + 2) + 20 + RANDOM_CYCLES + 2;
        localparam int WATCHDOG_NS = (TEST_CYCLES + 8 * GRANT_TIMEOUT) * CLK_PERIOD;

        typedef struct packed {
                arb_state_t st;
                rr_ptr_t    ptr;
                rr_ptr_t    win;
                int         left; // Grant cycles still to come, this one included.
        } model_t;

        logic        clk   = 1'b0;
        logic        rst_i = 1'b1;
        port_addr_t  s_addr;
        port_addr_t  w_addr;
        port_addr_t  e_addr;
        port_addr_t  l_addr;
        logic        grant_s;
        logic        grant_w;
        logic        grant_e;
        logic        grant_l;
        port_addr_t  to_cs;

        model_t      model;
        req_vec_t    exp_grants;
        port_addr_t  exp_cs;
        logic [31:0] rng_state   = 32'h95c1_4a58;
        string       cur_test    = "reset";
        int          errors      = 0;
        int          test_errors = 0;
        int          tests_run   = 0;
        int          tests_bad   = 0;

        n_rr_processor DUT (
                .clk              (clk),
                .rst_i            (rst_i),
                .s_nexthop_addr_i (s_addr),
                .w_nexthop_addr_i (w_addr),
                .e_nexthop_addr_i (e_addr),
                .l_nexthop_addr_i (l_addr),
                .grant_s_o        (grant_s),
                .grant_w_o        (grant_w),
                .grant_e_o        (grant_e),
                .grant_l_o        (grant_l),
                .to_cs_o          (to_cs)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic port_addr_t non_north_code(input logic [31:0] r);
                case (r % 5)
                        0:       return PORT_S;
                        1:       return PORT_W;
                        2:       return PORT_E;
                        3:       return PORT_L;
                        default: return PORT_NONE;
                endcase
        endfunction

        // Half of the addresses point north when north is allowed at all.
        function automatic port_addr_t random_addr(input logic allow_north);
                rng_state = xorshift(rng_state);
                if (allow_north && rng_state[0]) begin
                        return PORT_N;
                end
                return non_north_code(rng_state >> 8);
        endfunction

        function automatic req_vec_t grant_bits();
                return {grant_l, grant_e, grant_w, grant_s};
        endfunction

        function automatic int lowest_grant(input req_vec_t g);
                int idx;
                idx = -1;
                for (int k = N_IN - 1; k >= 0; k--) begin
                        if (g[k]) begin
                                idx = k;
                        end
                end
                return idx;
        endfunction

        function automatic model_t model_after_reset();
                model_t m;
                m.st   = ARB_IDLE;
                m.ptr  = IN_S;
                m.win  = IN_S;
                m.left = 0;
                return m;
        endfunction

        // Next arbiter state after one clock edge with these addresses applied.
        function automatic model_t ref_step(input model_t m, input port_addr_t s_a,
                                            input port_addr_t w_a, input port_addr_t e_a,
                                            input port_addr_t l_a);
                model_t   n;
                req_vec_t req;
                logic     found;
                int       idx;
                n      = m;
                found  = 1'b0;
                req[0] = (s_a == PORT_N);
                req[1] = (w_a == PORT_N);
                req[2] = (e_a == PORT_N);
                req[3] = (l_a == PORT_N);
                case (m.st)
                        ARB_IDLE: begin
                                for (int k = 0; k < N_IN; k++) begin
                                        idx = (int'(m.ptr) + k) % N_IN;
                                        if (!found && req[idx]) begin
                                                found  = 1'b1;
                                                n.st   = ARB_GRANT;
                                                n.win  = rr_ptr_t'(idx);
                                                n.left = FLITS;
                                        end
                                end
                        end
                        ARB_GRANT: begin
                                if (m.left <= 1) begin
                                        n.st  = ARB_RELEASE;
                                        n.ptr = rr_ptr_t'((int'(m.win) + 1) % N_IN);
                                end else begin
                                        n.left = m.left - 1;
                                end
                        end
                        default: begin
                                n.st = ARB_IDLE;
                        end
                endcase
                return n;
        endfunction

        function automatic req_vec_t expected_grants(input model_t m);
                req_vec_t g;
                g = '0;
                if (m.st == ARB_GRANT) begin
                        g[m.win] = 1'b1;
                end
                return g;
        endfunction

        function automatic port_addr_t expected_cs(input model_t m);
                if (m.st != ARB_GRANT) begin
                        return PORT_NONE;
                end
                case (m.win)
                        IN_S:    return PORT_S;
                        IN_W:    return PORT_W;
                        IN_E:    return PORT_E;
                        default: return PORT_L;
                endcase
        endfunction

        // Outputs are registered, so mid-cycle is a safe place to look at them.
        always @(negedge clk) begin
                if (rst_i !== 1'b0) begin
                        model = model_after_reset();
                end else begin
                        exp_grants = expected_grants(model);
                        exp_cs     = expected_cs(model);
                        if (grant_bits() !== exp_grants) begin
                                $display("mismatch %s: grants expected %b actual %b",
                                         cur_test, exp_grants, grant_bits());
                                errors++;
                        end
                        if (to_cs !== exp_cs) begin
                                $display("mismatch %s: to_cs expected %0d actual %0d",
                                         cur_test, exp_cs, to_cs);
                                errors++;
                        end
                        model = ref_step(model, s_addr, w_addr, e_addr, l_addr);
                end
        end

        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, cur_test);
                $display("Something failed");
                $finish;
        end

        task automatic drive_addrs(input port_addr_t s_a, input port_addr_t w_a,
                                   input port_addr_t e_a, input port_addr_t l_a);
                @(posedge clk);
                #DRIVE_DELAY;
                s_addr = s_a;
                w_addr = w_a;
                e_addr = e_a;
                l_addr = l_a;
        endtask

        task automatic apply_reset();
                drive_addrs(PORT_NONE, PORT_NONE, PORT_NONE, PORT_NONE);
                rst_i = 1'b1;
                repeat (2) @(posedge clk);
                #DRIVE_DELAY;
                rst_i = 1'b0;
        endtask

        task automatic start_test(input string name);
                cur_test    = name;
                test_errors = errors;
                tests_run++;
        endtask

        task automatic finish_test();
                if (errors == test_errors) begin
                        $display("test %-20s passed", cur_test);
                end else begin
                        $display("test %-20s FAILED with %0d errors",
                                 cur_test, errors - test_errors);
                        tests_bad++;
                end
        endtask

        task automatic check_idle();
                @(negedge clk);
                if (grant_bits() !== 4'b0000) begin
                        $display("mismatch %s: grants expected %b actual %b",
                                 cur_test, 4'b0000, grant_bits());
                        errors++;
                end
                if (to_cs !== PORT_NONE) begin
                        $display("mismatch %s: to_cs expected %0d actual %0d",
                                 cur_test, PORT_NONE, to_cs);
                        errors++;
                end
        endtask

        // Waits for a grant to rise; waited counts the cycles without it.
        task automatic wait_grant(output int idx, output int waited);
                req_vec_t prev;
                prev   = grant_bits();
                idx    = -1;
                waited = 0;
                while (idx < 0 && waited < GRANT_TIMEOUT) begin
                        @(negedge clk);
                        if (grant_bits() != 4'b0000 && prev == 4'b0000) begin
                                idx = lowest_grant(grant_bits());
                        end else begin
                                waited++;
                        end
                        prev = grant_bits();
                end
                if (idx < 0) begin
                        $display("test %s: no grant within %0d cycles", cur_test, GRANT_TIMEOUT);
                        errors++;
                end
        endtask

        task automatic check_winner(input int idx, input int exp_idx);
                if (idx != exp_idx) begin
                        $display("mismatch %s: winner expected %0d actual %0d", cur_test, exp_idx, idx);
                        errors++;
                end
        endtask

        task automatic single_requester_hold();
                int idx;
                int waited;
                int held;
                apply_reset();
                drive_addrs(PORT_E, PORT_N, PORT_L, PORT_S);
                wait_grant(idx, waited);
                check_winner(idx, IN_W);
                if (waited != 1) begin
                        $display("mismatch %s: grant latency expected 1 actual %0d",
                                 cur_test, waited);
                        errors++;
                end
                held = 0;
                while (grant_w && held <= FLITS) begin
                        if (to_cs != PORT_W) begin
                                $display("mismatch %s: to_cs expected %0d actual %0d",
                                         cur_test, PORT_W, to_cs);
                                errors++;
                        end
                        held++;
                        @(negedge clk);
                end
                if (held != FLITS) begin
                        $display("mismatch %s: hold cycles expected %0d actual %0d",
                                 cur_test, FLITS, held);
                        errors++;
                end
        endtask

        task automatic contention_rotation();
                int  idx;
                int  waited;
                int  spacing;
                time t_prev;
                time t_now;
                apply_reset();
                drive_addrs(PORT_N, PORT_N, PORT_N, PORT_N);
                t_prev = 0;
                for (int i = 0; i <= N_IN; i++) begin
                        wait_grant(idx, waited);
                        t_now = $time;
                        check_winner(idx, i % N_IN); // South first, then in ring order.
                        spacing = int'((t_now - t_prev) / CLK_PERIOD);
                        if (i > 0 && spacing != FLITS + 2) begin
                                $display("mismatch %s: grant spacing expected %0d actual %0d",
                                         cur_test, FLITS + 2, spacing);
                                errors++;
                        end
                        t_prev = t_now;
                end
        endtask

        task automatic fairness_after_gap();
                int idx;
                int waited;
                apply_reset();
                drive_addrs(PORT_W, PORT_S, PORT_N, PORT_E);
                wait_grant(idx, waited);
                check_winner(idx, IN_E);
                drive_addrs(PORT_N, PORT_S, PORT_W, PORT_N);
                wait_grant(idx, waited);
                check_winner(idx, IN_L);
        endtask

        initial begin
                s_addr = PORT_NONE;
                w_addr = PORT_NONE;
                e_addr = PORT_NONE;
                l_addr = PORT_NONE;
                repeat (2) @(posedge clk);
                #DRIVE_DELAY;
                rst_i = 1'b0;

                start_test("after_reset");
                drive_addrs(PORT_E, PORT_L, PORT_S, PORT_W);
                repeat (4) check_idle();
                finish_test();

                start_test("single_requester");
                single_requester_hold();
                finish_test();

                start_test("full_contention");
                contention_rotation();
                finish_test();

                start_test("fairness_after_gap");
                fairness_after_gap();
                finish_test();

                start_test("non_north_traffic");
                apply_reset();
                repeat (20) begin
                        drive_addrs(random_addr(1'b0), random_addr(1'b0),
                                    random_addr(1'b0), random_addr(1'b0));
                        check_idle();
                end
                finish_test();

                start_test("random_run");
                repeat (RANDOM_CYCLES) begin
                        drive_addrs(random_addr(1'b1), random_addr(1'b1),
                                    random_addr(1'b1), random_addr(1'b1));
                end
                repeat (2) @(negedge clk);
                finish_test();

                if (DUT.u_assertions.fail_onehot || DUT.u_assertions.fail_cs ||
                    DUT.u_assertions.fail_hold) begin
                        $display("a concurrent assertion on the grant outputs failed");
                        errors++;
                end
                $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_bad, errors);
                if (errors == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

// ==== noc_port_pkg.sv ====
package noc_port_pkg;

        // Next-hop address of a flit and select code of the crossbar share one width.
        typedef logic [2:0] port_addr_t;

        typedef enum port_addr_t {
                PORT_N    = 3'd0,
                PORT_S    = 3'd1,
                PORT_W    = 3'd2,
                PORT_E    = 3'd3,
                PORT_L    = 3'd4,
                PORT_NONE = 3'd7 // No port, crossbar left idle.
        } port_code_t;

endpackage

// ==== rr_arb_fsm.sv ====
`timescale 1ns/1ps

module rr_arb_fsm (
        input  logic                     clk,
        input  logic                     rst_i,
        input  rr_arb_pkg::rr_ptr_t      win_idx_i,
        input  logic                     win_valid_i,
        input  logic                     timer_done_i,
        output logic                     timer_load_o,
        output logic                     rotate_o,
        output rr_arb_pkg::rr_ptr_t      last_idx_o,
        output logic                     grant_s_o,
        output logic                     grant_w_o,
        output logic                     grant_e_o,
        output logic                     grant_l_o,
        output noc_port_pkg::port_addr_t to_cs_o
);

        import noc_port_pkg::*;
        import rr_arb_pkg::*;

        arb_state_t state_q;
        arb_state_t state_d;
        rr_ptr_t    win_q;
        req_vec_t   grant_vec;
        port_code_t cs_code;

        always_comb begin
                state_d = state_q;
                case (state_q)
                        ARB_IDLE: begin
                                if (win_valid_i) begin
                                        state_d = ARB_GRANT;
                                end
                        end
                        ARB_GRANT: begin
                                if (timer_done_i) begin
                                        state_d = ARB_RELEASE;
                                end
                        end
                        ARB_RELEASE: begin
                                state_d = ARB_IDLE; // One idle cycle on the crossbar.
                        end
                        default: begin
                                state_d = ARB_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        state_q <= ARB_IDLE;
                end else begin
                        state_q <= state_d;
                end
        end

        // Winner is sampled only when the grant starts; later requests wait.
        always_ff @(posedge clk) begin
                if (timer_load_o) begin
                        win_q <= win_idx_i;
                end
        end

        assign timer_load_o = (state_q == ARB_IDLE) && win_valid_i;
        assign rotate_o     = (state_q == ARB_GRANT) && timer_done_i;
        assign last_idx_o   = win_q;

        always_comb begin
                grant_vec = '0;
                cs_code   = PORT_NONE;
                if (state_q == ARB_GRANT) begin
                        grant_vec[win_q] = 1'b1;
                        case (win_q)
                                IN_S: cs_code = PORT_S;
                                IN_W: cs_code = PORT_W;
                                IN_E: cs_code = PORT_E;
                                IN_L: cs_code = PORT_L;
                                default: cs_code = PORT_NONE;
                        endcase
                end
        end

        assign grant_s_o = grant_vec[IN_S];
        assign grant_w_o = grant_vec[IN_W];
        assign grant_e_o = grant_vec[IN_E];
        assign grant_l_o = grant_vec[IN_L];
        assign to_cs_o   = cs_code;

endmodule

// ==== rr_arb_pkg.sv ====
`include "n_rr_config.svh"

package rr_arb_pkg;

        // One request bit per input, in the order S, W, E, L from bit 0.
        typedef logic [`N_RR_INPUTS-1:0] req_vec_t;

        // Index of an input, used for the pointer and for the winner.
        typedef logic [$clog2(`N_RR_INPUTS)-1:0] rr_ptr_t;

        localparam rr_ptr_t IN_S = 2'd0;
        localparam rr_ptr_t IN_W = 2'd1;
        localparam rr_ptr_t IN_E = 2'd2;
        localparam rr_ptr_t IN_L = 2'd3;

        typedef enum logic [1:0] {
                ARB_IDLE    = 2'd0,
                ARB_GRANT   = 2'd1, // Output owned by one input for a packet.
                ARB_RELEASE = 2'd2
        } arb_state_t;

endpackage

// ==== rr_grant_select.sv ====
`timescale 1ns/1ps

`include "n_rr_config.svh"

module rr_grant_select (
        input  rr_arb_pkg::req_vec_t req_i,
        input  rr_arb_pkg::rr_ptr_t  ptr_i,
        output rr_arb_pkg::rr_ptr_t  win_idx_o,
        output logic                 win_valid_o
);

        import rr_arb_pkg::*;

        localparam int unsigned N_IN = `N_RR_INPUTS;

        logic [2*N_IN-1:0] req_dbl;
        req_vec_t          req_rot;
        rr_ptr_t           offset;

        // Two copies of the requests side by side make the wrap-around a plain slice.
        assign req_dbl = {req_i, req_i};
        assign req_rot = req_dbl[ptr_i +: N_IN];

        // Bit 0 of the rotated vector is the input at the pointer.
        always_comb begin
                offset = '0;
                for (int k = N_IN - 1; k >= 0; k--) begin
                        if (req_rot[k]) begin
                                offset = rr_ptr_t'(k);
                        end
                end
        end

        // The index wraps by itself in its own width.
        assign win_idx_o   = ptr_i + offset;
        assign win_valid_o = |req_i;

endmodule

// ==== rr_priority_ring.sv ====
`timescale 1ns/1ps

`include "n_rr_config.svh"

module rr_priority_ring (
        input  logic                clk,
        input  logic                rst_i,
        input  logic                rotate_i,
        input  rr_arb_pkg::rr_ptr_t last_idx_i,
        output rr_arb_pkg::rr_ptr_t ptr_o
);

        import rr_arb_pkg::*;

        localparam rr_ptr_t LAST_INPUT = rr_ptr_t'(`N_RR_INPUTS - 1);

        rr_ptr_t ptr_q;
        rr_ptr_t ptr_next;

        // The input after the last winner gets the top priority.
        always_comb begin
                if (last_idx_i == LAST_INPUT) begin
                        ptr_next = IN_S;
                end else begin
                        ptr_next = last_idx_i + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        ptr_q <= IN_S; // South starts with the top priority.
                end else if (rotate_i) begin
                        ptr_q <= ptr_next;
                end
        end

        assign ptr_o = ptr_q;

endmodule
